// File: verilog/cnn_para_pkg.sv
package cnn_para_pkg;

    // one ieee half precision value
    typedef logic [15:0] fp16_t;

    localparam int FP16_SIGN = 15;   // sign bit position

    // word index into a feature map buffer, 8x8x2 words fit in 7 bits
    typedef logic [6:0] fm_addr_t;

    // side length or channel count
    typedef logic [3:0] fm_dim_t;

    // window generator states
    typedef enum logic [1:0] {
        IDLE,    // waiting for start
        SCAN,    // one pixel read per cycle
        FLUSH    // last pixel still on its way out of the ram
    } win_state_t;

    // pixel slot inside a 2x2 window, 0..3 in row-major order
    typedef logic [1:0] win_pix_t;

endpackage

// File: verilog/cnn_regs_pkg.sv
package cnn_regs_pkg;

    typedef logic [11:0] apb_addr_t;   // apb byte address

    // register map
    localparam apb_addr_t REG_CTRL       = 12'h000;   // bit 0 start
    localparam apb_addr_t REG_STATUS     = 12'h004;   // bit 0 busy, bit 1 layer_ready
    localparam apb_addr_t REG_FM_SIZE    = 12'h008;
    localparam apb_addr_t REG_FM_DEPTH   = 12'h00C;
    localparam apb_addr_t REG_ACTIVATION = 12'h010;
    localparam apb_addr_t FM_IN_BASE     = 12'h400;   // input pixels, one per word
    localparam apb_addr_t FM_OUT_BASE    = 12'h800;   // pooled results

    localparam int CTRL_START_BIT   = 0;
    localparam int STATUS_BUSY_BIT  = 0;
    localparam int STATUS_READY_BIT = 1;

    typedef enum logic {
        ACT_NONE = 1'b0,
        ACT_RELU = 1'b1
    } activation_t;

endpackage

// File: verilog/fm_ram.sv
`timescale 1ns/1ns

module fm_ram #(
    parameter int DEPTH_WORDS = 128
) (
    input  logic                   clk,
    input  logic                   we,
    input  cnn_para_pkg::fm_addr_t waddr,
    input  cnn_para_pkg::fp16_t    wdata,
    input  logic                   re,
    input  cnn_para_pkg::fm_addr_t raddr,
    output cnn_para_pkg::fp16_t    rdata
);
    import cnn_para_pkg::*;

    fp16_t mem [DEPTH_WORDS];   // one word per pixel

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (re) begin
            rdata <= mem[raddr];   // data shows up the cycle after re
        end
    end

endmodule

// File: verilog/apb_layer_regs.sv
`timescale 1ns/1ns

module apb_layer_regs #(
    parameter int FM_SIZE_MAX = 8,
    parameter int DEPTH_MAX   = 2
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  cnn_regs_pkg::apb_addr_t    paddr,
    input  logic [31:0]                pwdata,
    input  logic                       layer_done,
    input  cnn_para_pkg::fp16_t        out_rdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       start_pulse,
    output cnn_para_pkg::fm_dim_t      fm_size,
    output cnn_para_pkg::fm_dim_t      fm_depth,
    output cnn_regs_pkg::activation_t  activation,
    output logic                       in_we,
    output cnn_para_pkg::fm_addr_t     in_waddr,
    output cnn_para_pkg::fp16_t        in_wdata,
    output logic                       out_re,
    output cnn_para_pkg::fm_addr_t     out_raddr
);
    import cnn_para_pkg::*;
    import cnn_regs_pkg::*;

    localparam int FM_WORDS = FM_SIZE_MAX * FM_SIZE_MAX * DEPTH_MAX;

    logic busy;
    logic layer_ready;
    logic rd_wait;      // high in the second access cycle of an fm_out read
    logic access;
    logic aligned;
    logic in_hit;
    logic out_hit;
    logic reg_hit;
    logic in_ok;
    logic out_ok;
    logic start_req;
    logic start_err;
    logic err;
    logic wr_fire;

    // keep size and depth inside what the buffers and the scan can handle
    function automatic fm_dim_t clamp_dim(input logic [3:0] val, input int lo, input int hi);
        if (val < lo) begin
            return fm_dim_t'(lo);
        end
        if (val > hi) begin
            return fm_dim_t'(hi);
        end
        return val;
    endfunction

    assign access  = psel && penable;
    assign aligned = (paddr[1:0] == 2'b00);

    // buffer windows, word index taken from paddr[9:2]
    assign in_hit  = aligned && (paddr[11:10] == FM_IN_BASE[11:10])
                     && (int'(paddr[9:2]) < FM_WORDS);
    assign out_hit = aligned && (paddr[11:10] == FM_OUT_BASE[11:10])
                     && (int'(paddr[9:2]) < FM_WORDS);
    assign reg_hit = (paddr == REG_CTRL) || (paddr == REG_STATUS) ||
                     (paddr == REG_FM_SIZE) || (paddr == REG_FM_DEPTH) ||
                     (paddr == REG_ACTIVATION);

    // fm_in is write only and fm_out read only from the host side
    assign in_ok  = pwrite && in_hit && !busy;
    assign out_ok = !pwrite && out_hit && !busy;

    assign start_req = pwrite && (paddr == REG_CTRL) && pwdata[CTRL_START_BIT];
    assign start_err = start_req && busy;               // no restart mid layer
    assign err       = !(reg_hit || in_ok || out_ok) || start_err;

    assign pready  = !(out_ok && !rd_wait);   // one wait state on output reads only
    assign pslverr = access && err;
    assign wr_fire = access && pwrite && !err;

    // host ports into the two buffers
    assign in_we     = wr_fire && in_hit;
    assign in_waddr  = paddr[8:2];
    assign in_wdata  = pwdata[15:0];
    assign out_re    = access && out_ok && !rd_wait;   // read issued in first access cycle
    assign out_raddr = paddr[8:2];

    always_comb begin
        prdata = '0;
        if (out_ok) begin
            prdata = {16'h0000, out_rdata};
        end else begin
            case (paddr)
                REG_STATUS: begin
                    prdata[STATUS_BUSY_BIT]  = busy;
                    prdata[STATUS_READY_BIT] = layer_ready;
                end
                REG_FM_SIZE:    prdata[3:0] = fm_size;
                REG_FM_DEPTH:   prdata[3:0] = fm_depth;
                REG_ACTIVATION: prdata[0]   = activation;
                default:        prdata      = '0;    // ctrl start reads back as 0
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_wait     <= 1'b0;
            start_pulse <= 1'b0;
            busy        <= 1'b0;
            layer_ready <= 1'b0;
            fm_size     <= '0;
            fm_depth    <= '0;
            activation  <= ACT_NONE;
        end else begin
            rd_wait     <= access && out_ok && !rd_wait;
            start_pulse <= wr_fire && start_req;    // cycle after the ctrl write
            if (wr_fire && start_req) begin
                busy        <= 1'b1;
                layer_ready <= 1'b0;
            end else if (layer_done) begin
                busy        <= 1'b0;                // final output word written
                layer_ready <= 1'b1;
            end
            if (wr_fire && (paddr == REG_FM_SIZE)) begin
                fm_size <= clamp_dim(pwdata[3:0], 2, FM_SIZE_MAX);
            end
            if (wr_fire && (paddr == REG_FM_DEPTH)) begin
                fm_depth <= clamp_dim(pwdata[3:0], 1, DEPTH_MAX);
            end
            if (wr_fire && (paddr == REG_ACTIVATION)) begin
                activation <= activation_t'(pwdata[0]);
            end
        end
    end

endmodule

// File: verilog/pool_window_gen.sv
`timescale 1ns/1ns

module pool_window_gen (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   start_pulse,
    input  cnn_para_pkg::fm_dim_t  fm_size,
    input  cnn_para_pkg::fm_dim_t  fm_depth,
    output logic                   rd_en,
    output cnn_para_pkg::fm_addr_t rd_addr,
    output logic                   pix_valid,
    output logic                   pix_last
);
    import cnn_para_pkg::*;

    win_state_t state;
    fm_dim_t    ch;     // channel
    fm_dim_t    wr;     // window row
    fm_dim_t    wc;     // window column
    win_pix_t   pix;    // pixel inside the window
    fm_dim_t    half;   // windows per side
    fm_dim_t    row;
    fm_dim_t    col;
    logic       last_pix;
    logic       last_col;
    logic       last_row;
    logic       last_ch;

    assign half     = fm_size >> 1;       // 2x2 window, stride 2
    assign last_pix = (pix == 2'd3);
    assign last_col = (wc == half - 1'b1);
    assign last_row = (wr == half - 1'b1);
    assign last_ch  = (ch == fm_depth - 1'b1);

    // pixel order inside a window: top left, top right, bottom left, bottom right
    assign row = (wr << 1) + fm_dim_t'(pix[1]);
    assign col = (wc << 1) + fm_dim_t'(pix[0]);

    assign rd_en   = (state == SCAN);   // one read every scan cycle
    assign rd_addr = fm_addr_t'(ch) * fm_addr_t'(fm_size) * fm_addr_t'(fm_size)
                   + fm_addr_t'(row) * fm_addr_t'(fm_size) + fm_addr_t'(col);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            ch        <= '0;
            wr        <= '0;
            wc        <= '0;
            pix       <= '0;
            pix_valid <= 1'b0;
            pix_last  <= 1'b0;
        end else begin
            pix_valid <= rd_en;                 // lines up with ram rdata
            pix_last  <= rd_en && last_pix;
            case (state)
                IDLE: begin
                    if (start_pulse) begin
                        state <= SCAN;
                        ch    <= '0;
                        wr    <= '0;
                        wc    <= '0;
                        pix   <= '0;
                    end
                end
                SCAN: begin
                    pix <= pix + 1'b1;          // wraps to 0 after the fourth pixel
                    if (last_pix) begin
                        wc <= wc + 1'b1;
                        if (last_col) begin
                            wc <= '0;
                            wr <= wr + 1'b1;
                            if (last_row) begin
                                wr <= '0;
                                ch <= ch + 1'b1;
                                if (last_ch) begin
                                    state <= FLUSH;   // every window issued
                                end
                            end
                        end
                    end
                end
                FLUSH:   state <= IDLE;    // final pixel leaves the ram this cycle
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: verilog/fp16_max_stage.sv
`timescale 1ns/1ns

module fp16_max_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pix_valid,
    input  logic                pix_last,
    input  cnn_para_pkg::fp16_t pix_data,
    output logic                max_valid,
    output cnn_para_pkg::fp16_t max_data
);
    import cnn_para_pkg::*;

    fp16_t run_max;     // maximum so far in the current window
    fp16_t cand;
    logic  first;       // next valid pixel opens a new window

    // total order on sign and magnitude, +0 sits above -0
    function automatic logic fp16_gt(input fp16_t a, input fp16_t b);
        if (a[FP16_SIGN] != b[FP16_SIGN]) begin
            return b[FP16_SIGN];                // positive beats negative
        end
        if (!a[FP16_SIGN]) begin
            return a[14:0] > b[14:0];           // both positive, bigger magnitude wins
        end
        return a[14:0] < b[14:0];               // both negative, smaller magnitude wins
    endfunction

    always_comb begin
        if (first || fp16_gt(pix_data, run_max)) begin
            cand = pix_data;
        end else begin
            cand = run_max;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            first     <= 1'b1;
            max_valid <= 1'b0;
        end else begin
            max_valid <= pix_valid && pix_last;
            if (pix_valid) begin
                first <= pix_last;              // restart after the fourth pixel
            end
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            run_max <= cand;
            if (pix_last) begin
                max_data <= cand;
            end
        end
    end

endmodule

// File: verilog/activation_stage.sv
`timescale 1ns/1ns

module activation_stage (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      start_pulse,
    input  cnn_regs_pkg::activation_t activation,
    input  logic                      max_valid,
    input  cnn_para_pkg::fp16_t       max_data,
    input  cnn_para_pkg::fm_dim_t     fm_size,
    input  cnn_para_pkg::fm_dim_t     fm_depth,
    output logic                      out_we,
    output cnn_para_pkg::fm_addr_t    out_waddr,
    output cnn_para_pkg::fp16_t       out_wdata,
    output logic                      layer_done
);
    import cnn_para_pkg::*;
    import cnn_regs_pkg::*;

    fm_addr_t wr_idx;     // next output word
    fm_addr_t last_idx;   // (size/2)^2 * depth - 1
    fm_dim_t  half;

    assign half     = fm_size >> 1;
    assign last_idx = fm_addr_t'(half) * fm_addr_t'(half) * fm_addr_t'(fm_depth) - 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_idx     <= '0;
            out_we     <= 1'b0;
            layer_done <= 1'b0;
        end else begin
            out_we     <= max_valid;
            layer_done <= max_valid && (wr_idx == last_idx);   // same cycle as final write
            if (start_pulse) begin
                wr_idx <= '0;
            end else if (max_valid) begin
                wr_idx <= wr_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (max_valid) begin
            out_waddr <= wr_idx;
            // relu clears anything with the sign bit set, -0 included
            if (activation == ACT_RELU && max_data[FP16_SIGN]) begin
                out_wdata <= 16'h0000;
            end else begin
                out_wdata <= max_data;
            end
        end
    end

endmodule

// File: verilog/pool_layer_top.sv
`timescale 1ns/1ns

module pool_layer_top #(
    parameter int FM_SIZE_MAX = 8,
    parameter int DEPTH_MAX   = 2
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  cnn_regs_pkg::apb_addr_t paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr
);
    import cnn_para_pkg::*;
    import cnn_regs_pkg::*;

    localparam int DEPTH_WORDS = FM_SIZE_MAX * FM_SIZE_MAX * DEPTH_MAX;

    // control
    logic        start_pulse;
    logic        layer_done;
    fm_dim_t     fm_size;
    fm_dim_t     fm_depth;
    activation_t activation;

    // input buffer
    logic        in_we;
    fm_addr_t    in_waddr;
    fp16_t       in_wdata;
    logic        rd_en;
    fm_addr_t    rd_addr;
    fp16_t       rd_data;

    // pipeline
    logic        pix_valid;
    logic        pix_last;
    logic        max_valid;
    fp16_t       max_data;

    // output buffer
    logic        out_we;
    fm_addr_t    out_waddr;
    fp16_t       out_wdata;
    logic        out_re;
    fm_addr_t    out_raddr;
    fp16_t       out_rdata;

    apb_layer_regs #(
        .FM_SIZE_MAX (FM_SIZE_MAX),
        .DEPTH_MAX   (DEPTH_MAX)
    ) u_regs (
        .clk, .arst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .layer_done, .out_rdata,
        .prdata, .pready, .pslverr,
        .start_pulse, .fm_size, .fm_depth, .activation,
        .in_we, .in_waddr, .in_wdata,
        .out_re, .out_raddr
    );

    fm_ram #(.DEPTH_WORDS(DEPTH_WORDS)) u_fm_in (
        .clk,
        .we    (in_we),
        .waddr (in_waddr),
        .wdata (in_wdata),
        .re    (rd_en),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

    pool_window_gen u_win (
        .clk, .arst_n, .start_pulse, .fm_size, .fm_depth,
        .rd_en, .rd_addr, .pix_valid, .pix_last
    );

    fp16_max_stage u_max (
        .clk, .arst_n, .pix_valid, .pix_last,
        .pix_data  (rd_data),     // ram output lines up with pix_valid
        .max_valid, .max_data
    );

    activation_stage u_act (
        .clk, .arst_n, .start_pulse, .activation,
        .max_valid, .max_data, .fm_size, .fm_depth,
        .out_we, .out_waddr, .out_wdata, .layer_done
    );

    fm_ram #(.DEPTH_WORDS(DEPTH_WORDS)) u_fm_out (
        .clk,
        .we    (out_we),
        .waddr (out_waddr),
        .wdata (out_wdata),
        .re    (out_re),
        .raddr (out_raddr),
        .rdata (out_rdata)
    );

endmodule

// File: test/tb_pool_layer.sv
`timescale 1ns/1ns

module tb_pool_layer;
    import cnn_para_pkg::*;
    import cnn_regs_pkg::*;

    localparam int NUM_LAYERS  = 20;
    localparam int WR_CYC      = 3;    // idle, setup, access
    localparam int RD_CYC      = 4;    // output reads carry one wait state
    localparam int LAYER_CYC   = 128 * WR_CYC + 128 + 32 * RD_CYC + 100;
    localparam int TIMEOUT_CYC = (NUM_LAYERS + 4) * LAYER_CYC;   // four directed layers on top
    localparam int MAX_POLLS   = 200;

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    fp16_t       pix_mem [128];    // host copy of the input buffer
    int          cycle_cnt = 0;
    logic [31:0] rd;
    logic        err;
    int          size;
    int          depth;
    logic        relu;

    pool_layer_top #(
        .FM_SIZE_MAX (8),
        .DEPTH_MAX   (2)
    ) u_dut (
        .clk, .arst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;    // 8 ns period

    // print the reason, then the fail line, then stop
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            stop_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            stop_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYC));
        end
    end

    // one apb transfer, returns after the completing edge
    task automatic bus_transfer(input logic wr, input apb_addr_t addr, input logic [31:0] wdata,
                                input int exp_waits,
                                output logic [31:0] rdata, output logic slverr);
        int waits;
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);             // outputs settled mid cycle
        while (!pready) begin
            waits++;                // access cycle without pready
            @(negedge clk);
        end
        rdata  = prdata;
        slverr = pslverr;
        @(posedge clk);             // access completes here
        psel    <= 1'b0;
        penable <= 1'b0;
        expect_eq($sformatf("pready wait states %h", addr), 32'(waits), 32'(exp_waits));
    endtask

    task automatic write_apb(input apb_addr_t addr, input logic [31:0] data);
        logic [31:0] dummy;
        logic        slverr;
        bus_transfer(1'b1, addr, data, 0, dummy, slverr);   // writes never wait
        expect_eq($sformatf("pslverr write %h", addr), 32'(slverr), 32'h0);
    endtask

    task automatic read_apb(input apb_addr_t addr, output logic [31:0] data);
        logic slverr;
        int   exp_waits;
        exp_waits = (addr[11:10] == FM_OUT_BASE[11:10]) ? 1 : 0;   // ram read costs a cycle
        bus_transfer(1'b0, addr, 32'h0, exp_waits, data, slverr);
        expect_eq($sformatf("pslverr read %h", addr), 32'(slverr), 32'h0);
    endtask

    // sortable key, negatives below positives, -0 just under +0
    function automatic logic [15:0] order_key(input fp16_t v);
        if (v[15]) begin
            return 16'h7FFF - {1'b0, v[14:0]};   // bigger magnitude sorts lower
        end
        return 16'h8000 | {1'b0, v[14:0]};
    endfunction

    function automatic fp16_t model_pool(input int s, input int ch, input int wr, input int wc);
        fp16_t best;
        fp16_t v;
        int    idx;
        int    k;
        best = pix_mem[ch * s * s + (2 * wr) * s + 2 * wc];
        for (k = 1; k < 4; k++) begin
            idx = ch * s * s + (2 * wr + k / 2) * s + 2 * wc + k % 2;
            v   = pix_mem[idx];
            if (order_key(v) > order_key(best)) begin
                best = v;
            end
        end
        return best;
    endfunction

    function automatic fp16_t model_act(input fp16_t v, input logic relu_on);
        return (relu_on && v[15]) ? 16'h0000 : v;
    endfunction

    task automatic fill_random(input int n);
        fp16_t px;
        for (int i = 0; i < n; i++) begin
            px = fp16_t'($urandom);
            if (&px[14:10]) begin
                px[14] = 1'b0;      // stay clear of inf and nan
            end
            pix_mem[i] = px;
        end
    endtask

    task automatic load_pixels(input int n);
        for (int i = 0; i < n; i++) begin
            write_apb(FM_IN_BASE + apb_addr_t'(i * 4), {16'h0000, pix_mem[i]});
        end
    endtask

    task automatic start_layer(input int s, input int d, input logic relu_on);
        write_apb(REG_FM_SIZE, 32'(s));
        write_apb(REG_FM_DEPTH, 32'(d));
        write_apb(REG_ACTIVATION, {31'h0, relu_on});
        write_apb(REG_CTRL, 32'h1);      // start
    endtask

    task automatic wait_ready();
        logic [31:0] st;
        int          polls;
        polls = 0;
        read_apb(REG_STATUS, st);
        while (!st[STATUS_READY_BIT]) begin
            polls++;
            if (polls > MAX_POLLS) begin
                stop_run("layer_ready never came up in the STATUS register");
            end
            read_apb(REG_STATUS, st);
        end
        expect_eq("status", st, 32'h2);   // ready and no longer busy
    endtask

    task automatic check_outputs(input int s, input int d, input logic relu_on);
        logic [31:0] got;
        fp16_t       exp;
        int          half;
        int          idx;
        half = s / 2;
        for (int ch = 0; ch < d; ch++) begin
            for (int wr = 0; wr < half; wr++) begin
                for (int wc = 0; wc < half; wc++) begin
                    idx = ch * half * half + wr * half + wc;
                    exp = model_act(model_pool(s, ch, wr, wc), relu_on);
                    read_apb(FM_OUT_BASE + apb_addr_t'(idx * 4), got);
                    if (relu_on) begin
                        assert (!got[15]) else begin
                            stop_run($sformatf("FAILED prdata out[%0d] got %h with sign set",
                                               idx, got));
                        end
                    end else if (exp[15]) begin
                        // negative maximum has to come through untouched
                        assert (got[15]) else begin
                            stop_run($sformatf("FAILED prdata out[%0d] got %h expected %h",
                                               idx, got, {16'h0000, exp}));
                        end
                    end
                    expect_eq($sformatf("prdata out[%0d]", idx), got, {16'h0000, exp});
                end
            end
        end
    endtask

    task automatic run_layer(input int s, input int d, input logic relu_on);
        load_pixels(s * s * d);
        start_layer(s, d, relu_on);
        wait_ready();
        check_outputs(s, d, relu_on);
    endtask

    initial begin
        arst_n  = 1'b0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        void'($urandom(32'ha382));
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        read_apb(REG_STATUS, rd);               // idle after reset
        expect_eq("status after reset", rd, 32'h0);

        bus_transfer(1'b1, 12'h014, 32'h1, 0, rd, err);   // hole in the register map
        expect_eq("pslverr unmapped write", 32'(err), 32'h1);
        bus_transfer(1'b0, 12'hC00, 32'h0, 0, rd, err);
        expect_eq("pslverr unmapped read", 32'(err), 32'h1);

        // +0, -0, negative, -0 must give +0
        pix_mem[0] = 16'h0000;
        pix_mem[1] = 16'h8000;
        pix_mem[2] = 16'hC000;
        pix_mem[3] = 16'h8000;
        run_layer(2, 1, 1'b0);
        read_apb(FM_OUT_BASE, rd);
        expect_eq("prdata signed zero window", rd, 32'h0000_0000);

        // all negative, smallest magnitude wins
        pix_mem[0] = 16'hC400;
        pix_mem[1] = 16'hBC00;
        pix_mem[2] = 16'hC000;
        pix_mem[3] = 16'hB800;
        run_layer(2, 1, 1'b0);
        read_apb(FM_OUT_BASE, rd);
        expect_eq("prdata negative window", rd, 32'h0000_B800);

        // full buffer with a rejected write just past it, aliases onto word 0
        fill_random(128);
        load_pixels(128);
        bus_transfer(1'b1, FM_IN_BASE + 12'h200, 32'h0000_7BFF, 0, rd, err);
        expect_eq("pslverr fm_in beyond buffer", 32'(err), 32'h1);
        start_layer(8, 2, 1'b0);
        bus_transfer(1'b0, FM_OUT_BASE, 32'h0, 0, rd, err);   // layer still running
        expect_eq("pslverr fm_out while busy", 32'(err), 32'h1);
        wait_ready();
        check_outputs(8, 2, 1'b0);

        // smaller layer over the same buffers
        fill_random(16);
        run_layer(4, 1, 1'b0);

        for (int n = 0; n < NUM_LAYERS; n++) begin
            size  = 2 * int'($urandom_range(1, 4));
            depth = int'($urandom_range(1, 2));
            relu  = 1'($urandom_range(0, 1));
            fill_random(size * size * depth);
            run_layer(size, depth, relu);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: build.f
verilog/cnn_para_pkg.sv
verilog/cnn_regs_pkg.sv
verilog/fm_ram.sv
verilog/apb_layer_regs.sv
verilog/pool_window_gen.sv
verilog/fp16_max_stage.sv
verilog/activation_stage.sv
verilog/pool_layer_top.sv
test/tb_pool_layer.sv

// File: run.sh
#!/bin/sh
# build and run the pooling layer testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_pool_layer -f build.f \
    -o sim_pool_layer &&
./obj_dir/sim_pool_layer ||
exit 1
